// ==== source/rp_pkg.sv ====
package rp_pkg;

  //////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;   // Raw converter word, 2 reserved LSBs
  localparam int SAMPLE_W  = 14;   // Conditioned ADC and DAC sample
  localparam int PDM_W     = 8;    // PDM level
  localparam int PDM_RANGE = 255;  // Accumulator modulus
  localparam int PDM_CH    = 4;    // Number of PDM outputs
  localparam int LED_W     = 8;
  localparam int WB_ADR_W  = 4;    // Word index, not byte address
  localparam int WB_DAT_W  = 32;

  // Signed sample limits, used by the DAC saturation
  localparam int SAMPLE_MAX = 2**(SAMPLE_W-1) - 1;
  localparam int SAMPLE_MIN = -(2**(SAMPLE_W-1));

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;   // Unsigned, negative slope
  typedef logic signed [SAMPLE_W-1:0]  sample_t;    // Two's complement
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // Converter code, negative slope
  typedef logic        [PDM_W-1:0]     pdm_cfg_t;
  typedef logic        [LED_W-1:0]     led_t;
  typedef logic        [WB_ADR_W-1:0]  wb_addr_t;
  typedef logic        [WB_DAT_W-1:0]  wb_data_t;

  //////////////////////////////////////////////////
  // Housekeeping register map
  //////////////////////////////////////////////////

  localparam wb_data_t HK_ID = 32'h5250_0A14;  // Read-only ID word

  localparam wb_addr_t REG_ID   = 4'd0;
  localparam wb_addr_t REG_LOOP = 4'd1;  // Bit 0, digital loopback
  localparam wb_addr_t REG_LED  = 4'd2;  // Low byte, LEDs
  // Index 3 unmapped
  localparam wb_addr_t REG_PDM0 = 4'd4;  // PDM levels at 4..7

endpackage

// ==== source/adc_frontend.sv ====
`timescale 1ns/1ns

module adc_frontend (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::adc_raw_t adc_a_i,    // Raw converter word, CH A
  input  rp_pkg::adc_raw_t adc_b_i,    // Raw converter word, CH B
  input  logic             loop_en_i,  // Digital loopback select
  input  rp_pkg::sample_t  loop_a_i,   // Saturated DAC sample, CH A
  input  rp_pkg::sample_t  loop_b_i,   // Saturated DAC sample, CH B
  output rp_pkg::sample_t  adc_a_o,
  output rp_pkg::sample_t  adc_b_o
);

  import rp_pkg::*;

  // Strip reserved LSBs, turn negative slope into two's complement
  function automatic sample_t adc_conv(input adc_raw_t raw);
    logic [SAMPLE_W-1:0] top;
    top = raw[ADC_RAW_W-1 -: SAMPLE_W];  // Bits 15..2
    // MSB kept, the rest inverted
    return sample_t'({top[SAMPLE_W-1], ~top[SAMPLE_W-2:0]});
  endfunction

  sample_t conv_a;
  sample_t conv_b;

  assign conv_a = adc_conv(adc_a_i);
  assign conv_b = adc_conv(adc_b_i);

  // One register stage, converter or loopback per channel
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= loop_en_i ? loop_a_i : conv_a;  // Loopback replaces converter
      adc_b_o <= loop_en_i ? loop_b_i : conv_b;
    end
  end

endmodule

// ==== source/dac_mixer.sv ====
`timescale 1ns/1ns

module dac_mixer (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::sample_t   asg_a_i,  // Generator, CH A
  input  rp_pkg::sample_t   asg_b_i,  // Generator, CH B
  input  rp_pkg::sample_t   pid_a_i,  // Controller, CH A
  input  rp_pkg::sample_t   pid_b_i,  // Controller, CH B
  output rp_pkg::sample_t   sat_a_o,  // Stage 1, also the loopback source
  output rp_pkg::sample_t   sat_b_o,
  output rp_pkg::dac_code_t dac_a_o,  // Stage 2, converter code
  output rp_pkg::dac_code_t dac_b_o
);

  import rp_pkg::*;

  // Clamp a 15-bit sum into the 14-bit signed range
  function automatic sample_t sat(input logic signed [SAMPLE_W:0] sum);
    if (sum > SAMPLE_MAX) begin
      return sample_t'(SAMPLE_MAX);
    end else if (sum < SAMPLE_MIN) begin
      return sample_t'(SAMPLE_MIN);
    end
    return sample_t'(sum);
  endfunction

  // Signed to negative-slope code, sign kept
  function automatic dac_code_t dac_enc(input sample_t s);
    return {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // Stage 1, sum and saturate
  //////////////////////////////////////////////////

  logic signed [SAMPLE_W:0] sum_a;  // One guard bit
  logic signed [SAMPLE_W:0] sum_b;

  assign sum_a = (SAMPLE_W+1)'(asg_a_i) + (SAMPLE_W+1)'(pid_a_i);
  assign sum_b = (SAMPLE_W+1)'(asg_b_i) + (SAMPLE_W+1)'(pid_b_i);

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sat_a_o <= '0;
      sat_b_o <= '0;
    end else begin
      sat_a_o <= sat(sum_a);
      sat_b_o <= sat(sum_b);
    end
  end

  //////////////////////////////////////////////////
  // Stage 2, DAC encoding
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_a_o <= '0;  // Zero code out of reset, not midscale
      dac_b_o <= '0;
    end else begin
      dac_a_o <= dac_enc(sat_a_o);
      dac_b_o <= dac_enc(sat_b_o);
    end
  end

  // Overflowed sum lands on the limit of its own sign next cycle
  a_sat_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sum_a > SAMPLE_MAX || sum_a < SAMPLE_MIN) |=>
    (sat_a_o == ($past(sum_a[SAMPLE_W]) ? sample_t'(SAMPLE_MIN) : sample_t'(SAMPLE_MAX))));
  a_sat_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sum_b > SAMPLE_MAX || sum_b < SAMPLE_MIN) |=>
    (sat_b_o == ($past(sum_b[SAMPLE_W]) ? sample_t'(SAMPLE_MIN) : sample_t'(SAMPLE_MAX))));

endmodule

// ==== source/pdm_modulator.sv ====
`timescale 1ns/1ns

module pdm_modulator (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  rp_pkg::pdm_cfg_t          cfg_i [rp_pkg::PDM_CH],  // Levels, 0..255
  output logic [rp_pkg::PDM_CH-1:0] pdm_o                    // One bit per channel
);

  import rp_pkg::*;

  pdm_cfg_t       acc     [PDM_CH];  // Residue, always below PDM_RANGE
  logic [PDM_W:0] acc_sum [PDM_CH];  // Carry bit for the compare

  // Next residue before the modulus
  always_comb begin
    for (int i = 0; i < PDM_CH; i++) begin
      acc_sum[i] = {1'b0, acc[i]} + {1'b0, cfg_i[i]};
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      pdm_o <= '0;
      for (int i = 0; i < PDM_CH; i++) begin
        acc[i] <= '0;
      end
    end else begin
      for (int i = 0; i < PDM_CH; i++) begin
        if (acc_sum[i] >= PDM_RANGE) begin
          acc[i]   <= PDM_W'(acc_sum[i] - PDM_RANGE);  // Wrap
          pdm_o[i] <= 1'b1;
        end else begin
          acc[i]   <= PDM_W'(acc_sum[i]);
          pdm_o[i] <= 1'b0;
        end
      end
    end
  end

  // Level 255 keeps the residue fixed, so the bound holds for all levels
  for (genvar g = 0; g < PDM_CH; g++) begin : g_acc_chk
    a_acc_range: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      acc[g] < PDM_RANGE);
  end

endmodule

// ==== source/hk_regs.sv ====
`timescale 1ns/1ns

module hk_regs (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  // Wishbone classic slave
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  rp_pkg::wb_addr_t wb_adr_i,  // Word index
  input  rp_pkg::wb_data_t wb_dat_i,
  output rp_pkg::wb_data_t wb_dat_o,
  output logic             wb_ack_o,
  // Configuration out
  output logic             loop_en_o,
  output rp_pkg::led_t     led_o,
  output rp_pkg::pdm_cfg_t pdm_cfg_o [rp_pkg::PDM_CH]
);

  import rp_pkg::*;

  typedef enum logic {
    ACK_IDLE,  // Waiting for cyc and stb
    ACK_HIGH   // Single ack cycle
  } ack_state_t;

  ack_state_t ack_state;

  logic                      bus_req;  // New access seen while ack low
  logic                      pdm_hit;
  logic [$clog2(PDM_CH)-1:0] pdm_sel;
  wb_data_t                  rd_data;

  assign bus_req  = wb_cyc_i && wb_stb_i && (ack_state == ACK_IDLE);
  assign pdm_hit  = (wb_adr_i >= REG_PDM0) && (wb_adr_i < REG_PDM0 + PDM_CH);
  assign pdm_sel  = $bits(pdm_sel)'(wb_adr_i - REG_PDM0);
  assign wb_ack_o = (ack_state == ACK_HIGH);

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;  // Unmapped reads zero
    if (pdm_hit) begin
      rd_data = wb_data_t'(pdm_cfg_o[pdm_sel]);
    end else begin
      case (wb_adr_i)
        REG_ID:   rd_data = HK_ID;
        REG_LOOP: rd_data = wb_data_t'(loop_en_o);
        REG_LED:  rd_data = wb_data_t'(led_o);
        default:  rd_data = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Ack FSM and register writes
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ack_state <= ACK_IDLE;
    end else begin
      case (ack_state)
        ACK_IDLE: if (bus_req) ack_state <= ACK_HIGH;
        ACK_HIGH: ack_state <= ACK_IDLE;  // Ack lasts one cycle only
        default:  ack_state <= ACK_IDLE;
      endcase
    end
  end

  // Write lands on the same edge that raises ack
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      wb_dat_o  <= '0;
      loop_en_o <= 1'b0;
      led_o     <= '0;
      for (int i = 0; i < PDM_CH; i++) begin
        pdm_cfg_o[i] <= '0;
      end
    end else if (bus_req) begin
      wb_dat_o <= rd_data;  // Held for the ack cycle
      if (wb_we_i) begin
        if (pdm_hit) begin
          pdm_cfg_o[pdm_sel] <= wb_dat_i[PDM_W-1:0];
        end else if (wb_adr_i == REG_LOOP) begin
          loop_en_o <= wb_dat_i[0];
        end else if (wb_adr_i == REG_LED) begin
          led_o <= wb_dat_i[LED_W-1:0];
        end
        // REG_ID and index 3 drop the write
      end
    end
  end

  // Ack is a single pulse, answering a request from the cycle before
  a_ack_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o);
  a_ack_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// ==== source/rp_analog_top.sv ====
`timescale 1ns/1ns

module rp_analog_top (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  // Converter and application samples
  input  rp_pkg::adc_raw_t          adc_a_i,
  input  rp_pkg::adc_raw_t          adc_b_i,
  input  rp_pkg::sample_t           asg_a_i,  // From generator
  input  rp_pkg::sample_t           asg_b_i,
  input  rp_pkg::sample_t           pid_a_i,  // From controller
  input  rp_pkg::sample_t           pid_b_i,
  // Wishbone classic slave
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  rp_pkg::wb_addr_t          wb_adr_i,
  input  rp_pkg::wb_data_t          wb_dat_i,
  output rp_pkg::wb_data_t          wb_dat_o,
  output logic                      wb_ack_o,
  // Outputs
  output rp_pkg::sample_t           adc_a_o,  // To scope, generator, controller
  output rp_pkg::sample_t           adc_b_o,
  output rp_pkg::dac_code_t         dac_a_o,
  output rp_pkg::dac_code_t         dac_b_o,
  output logic [rp_pkg::PDM_CH-1:0] dac_pwm_o,
  output rp_pkg::led_t              led_o
);

  import rp_pkg::*;

  logic     loop_en;
  sample_t  sat_a;             // Saturated sums, fed back for loopback
  sample_t  sat_b;
  pdm_cfg_t pdm_cfg [PDM_CH];

  //////////////////////////////////////////////////
  // Sample path
  //////////////////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_a_i   (adc_a_i),
    .adc_b_i   (adc_b_i),
    .loop_en_i (loop_en),
    .loop_a_i  (sat_a),
    .loop_b_i  (sat_b),
    .adc_a_o   (adc_a_o),
    .adc_b_o   (adc_b_o)
  );

  dac_mixer dac_mixer_inst (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .sat_a_o (sat_a),
    .sat_b_o (sat_b),
    .dac_a_o (dac_a_o),
    .dac_b_o (dac_b_o)
  );

  //////////////////////////////////////////////////
  // Housekeeping and PDM
  //////////////////////////////////////////////////

  hk_regs hk_regs_inst (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .loop_en_o (loop_en),
    .led_o     (led_o),     // LEDs straight from the register
    .pdm_cfg_o (pdm_cfg)
  );

  pdm_modulator pdm_modulator_inst (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .cfg_i   (pdm_cfg),
    .pdm_o   (dac_pwm_o)
  );

endmodule

// ==== test/tb_rp_analog.sv ====
`timescale 1ns/1ns

module tb_rp_analog;

  import rp_pkg::*;

  localparam int RST_CYC = 10;
  localparam int N_RAND  = 1000;  // Loopback off
  localparam int N_LOOP  = 500;   // Loopback on
  localparam int N_PDM   = 255;   // One full PDM period
  // Test lengths plus margin for register accesses and settling
  localparam int TIMEOUT = 2 * (RST_CYC + N_RAND + N_LOOP + N_PDM) + 1000;

  logic              adc_clk = 1'b0;
  logic              rst_n_i;
  adc_raw_t          adc_a_i, adc_b_i;
  sample_t           asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  logic              wb_cyc_i, wb_stb_i, wb_we_i;
  wb_addr_t          wb_adr_i;
  wb_data_t          wb_dat_i, wb_dat_o;
  logic              wb_ack_o;
  sample_t           adc_a_o, adc_b_o;
  dac_code_t         dac_a_o, dac_b_o;
  logic [PDM_CH-1:0] dac_pwm_o;
  led_t              led_o;

  logic [31:0] lcg_state = 32'h4044e2a5;
  int          cycles = 0;
  int          err_sample = 0, err_dac = 0, err_reg = 0, err_count = 0, err_other = 0;
  int          n_hi = 0, n_lo = 0;                  // Saturation hits, CH A
  int          pdm_lvl [PDM_CH] = '{0, 1, 128, 255};
  wb_data_t    rd;

  always #10 adc_clk = ~adc_clk;  // 20 ns period

  rp_analog_top rp_analog_top_inst (.*);

  // Watchdog
  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Negative slope code, 0 is full positive scale
  function automatic sample_t expect_adc(input adc_raw_t raw);
    return sample_t'(SAMPLE_MAX - int'(raw[ADC_RAW_W-1:2]));
  endfunction

  function automatic dac_code_t expect_dac(input sample_t s);
    return dac_code_t'(SAMPLE_MAX - int'(s));
  endfunction

  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > SAMPLE_MAX) s = SAMPLE_MAX;
    if (s < SAMPLE_MIN) s = SAMPLE_MIN;
    return sample_t'(s);
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      err_sample++;
      $display("Fail %s: expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic check_dac(input string name, input dac_code_t exp, input dac_code_t act);
    if (act !== exp) begin
      err_dac++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp) begin
      err_reg++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      err_count++;
      $display("Fail %s: expected %0d, got %0d", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Classic cycle, held until ack
  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           output wb_data_t rdat);
    @(posedge adc_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    do @(negedge adc_clk); while (!wb_ack_o);
    rdat = wb_dat_o;  // Valid during ack
    @(posedge adc_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  // Free-running samples, outputs checked at the falling edge
  task automatic run_random(input string name, input int n, input logic loop_on);
    adc_raw_t raw_a, raw_b, raw_a_d1, raw_b_d1;
    sample_t  ga, gb, pa, pb;
    sample_t  sat_a_d1, sat_b_d1, sat_a_d2, sat_b_d2;  // 2-deep history
    int       s;
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      raw_a = adc_raw_t'(next_rand() >> 16);
      raw_b = adc_raw_t'(next_rand() >> 16);
      ga = sample_t'(next_rand() >> 18);  // Full range
      gb = sample_t'(next_rand() >> 18);
      pa = sample_t'(next_rand() >> 18);
      pb = sample_t'(next_rand() >> 18);
      adc_a_i <= raw_a;
      adc_b_i <= raw_b;
      asg_a_i <= ga;
      asg_b_i <= gb;
      pid_a_i <= pa;
      pid_b_i <= pb;
      @(negedge adc_clk);
      if (i >= 1 && !loop_on) begin
        check_sample({name, " adc_a"}, expect_adc(raw_a_d1), adc_a_o);
        check_sample({name, " adc_b"}, expect_adc(raw_b_d1), adc_b_o);
      end
      if (i >= 2) begin
        check_dac({name, " dac_a"}, expect_dac(sat_a_d2), dac_a_o);
        check_dac({name, " dac_b"}, expect_dac(sat_b_d2), dac_b_o);
        if (loop_on) begin
          check_sample({name, " adc_a"}, sat_a_d2, adc_a_o);
          check_sample({name, " adc_b"}, sat_b_d2, adc_b_o);
        end
      end
      s = int'(ga) + int'(pa);
      if (s > SAMPLE_MAX) n_hi++;
      if (s < SAMPLE_MIN) n_lo++;
      sat_a_d2 = sat_a_d1;
      sat_b_d2 = sat_b_d1;
      sat_a_d1 = sat_sum(ga, pa);
      sat_b_d1 = sat_sum(gb, pb);
      raw_a_d1 = raw_a;
      raw_b_d1 = raw_b;
    end
  endtask

  task automatic count_pdm();
    int ones [PDM_CH];
    for (int c = 0; c < PDM_CH; c++) ones[c] = 0;
    repeat (8) @(negedge adc_clk);  // Settle on new levels
    for (int t = 0; t < N_PDM; t++) begin
      @(negedge adc_clk);
      for (int c = 0; c < PDM_CH; c++) ones[c] += int'(dac_pwm_o[c]);
    end
    for (int c = 0; c < PDM_CH; c++) check_count($sformatf("pdm%0d ones", c), pdm_lvl[c], ones[c]);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n_i  <= 1'b0;
    adc_a_i  <= '0;
    adc_b_i  <= '0;
    asg_a_i  <= '0;
    asg_b_i  <= '0;
    pid_a_i  <= '0;
    pid_b_i  <= '0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    repeat (RST_CYC - 1) @(posedge adc_clk);
    @(negedge adc_clk);
    check_sample("reset adc_a", '0, adc_a_o);
    check_sample("reset adc_b", '0, adc_b_o);
    check_dac("reset dac_a", '0, dac_a_o);
    check_dac("reset dac_b", '0, dac_b_o);
    check_reg("reset wb_dat", '0, wb_dat_o);
    check_reg("reset led", '0, wb_data_t'(led_o));
    check_count("reset ack", 0, int'(wb_ack_o));
    check_count("reset pdm", 0, int'(dac_pwm_o));
    @(posedge adc_clk);
    rst_n_i <= 1'b1;

    run_random("random", N_RAND, 1'b0);
    if (n_hi == 0 || n_lo == 0) begin
      err_other++;
      $display("Random samples never drove the sum past both limits");
    end

    // Register map
    wb_write(REG_ID, 32'hFFFF_FFFF);  // Read-only
    wb_read(REG_ID, rd);
    check_reg("reg id", HK_ID, rd);
    wb_write(REG_LED, 32'h1234_56A5);
    wb_read(REG_LED, rd);
    check_reg("reg led", 32'h0000_00A5, rd);
    check_reg("led_o", 32'h0000_00A5, wb_data_t'(led_o));
    wb_write(4'd3, 32'hDEAD_BEEF);
    wb_read(4'd3, rd);
    check_reg("unmapped 3", '0, rd);
    wb_read(4'd12, rd);
    check_reg("unmapped 12", '0, rd);

    // PDM levels and duty
    for (int c = 0; c < PDM_CH; c++) wb_write(REG_PDM0 + wb_addr_t'(c), wb_data_t'(pdm_lvl[c]));
    for (int c = 0; c < PDM_CH; c++) begin
      wb_read(REG_PDM0 + wb_addr_t'(c), rd);
      check_reg($sformatf("reg pdm%0d", c), wb_data_t'(pdm_lvl[c]), rd);
    end
    count_pdm();

    wb_write(REG_LOOP, 32'h1);
    run_random("loopback", N_LOOP, 1'b1);

    $display("Errors: sample %0d, dac %0d, reg %0d, count %0d, other %0d",
             err_sample, err_dac, err_reg, err_count, err_other);
    if (err_sample + err_dac + err_reg + err_count + err_other == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== rp_analog.f ====
source/rp_pkg.sv
source/adc_frontend.sv
source/dac_mixer.sv
source/pdm_modulator.sv
source/hk_regs.sv
source/rp_analog_top.sv
test/tb_rp_analog.sv

// ==== Makefile ====
TOP := tb_rp_analog

obj_dir/V$(TOP): rp_analog.f $(shell cat rp_analog.f)
	verilator --binary --timing --assert -Wno-fatal -f rp_analog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
